/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int XLEN        = 32;
    localparam int TAG_W       = 4;
    localparam int IMM_W       = 12;
    localparam int LSB_DEPTH   = 8;
    localparam int IDX_W       = 3;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 2;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_size_e;

    // renamed op as it leaves the dispatcher
    typedef struct packed {
        lsu_op_e              op;
        logic [TAG_W-1:0]     dest_tag;
        logic [IMM_W-1:0]     imm;
        logic [TAG_W-1:0]     rs1_tag;
        logic [XLEN-1:0]      rs1_data;
        logic [TAG_W-1:0]     rs2_tag;
        logic [XLEN-1:0]      rs2_data;
    } dispatch_t;

    typedef struct packed {
        logic                 is_store;
        access_size_e         size;
        logic                 is_unsigned;
        logic [TAG_W-1:0]     dest_tag;
        logic [IMM_W-1:0]     imm;
        logic                 rs1_ready;
        logic [TAG_W-1:0]     rs1_tag;
        logic [XLEN-1:0]      rs1_data;
        logic                 rs2_ready;
        logic [TAG_W-1:0]     rs2_tag;
        logic [XLEN-1:0]      rs2_data;
    } lsb_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     tag;
        logic [XLEN-1:0]      data;
    } cdb_t;

    // tag rides along so the result stage can broadcast it
    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        access_size_e         size;
        logic                 is_unsigned;
        logic [IDX_W-1:0]     idx;
        logic [TAG_W-1:0]     tag;
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [IDX_W-1:0]     idx;
        logic [TAG_W-1:0]     tag;
        access_size_e         size;
        logic                 is_unsigned;
        logic [XLEN-1:0]      raw;
        logic [1:0]           lo;
    } mem_resp_t;

endpackage

`default_nettype wire

/* hw/lsu_dispatch_decode.sv */
`default_nettype none

module lsu_dispatch_decode import lsu_pkg::*; (
    input  dispatch_t  dispatch,
    input  logic       dispatch_valid,
    output lsb_entry_t decoded,
    output logic       decoded_valid
);

    logic is_mem;

    always_comb begin
        is_mem              = 1'b1;
        decoded.is_store    = 1'b0;
        decoded.size        = WORD;
        decoded.is_unsigned = 1'b0;

        case (dispatch.op)
            LB:  decoded.size = BYTE;
            LH:  decoded.size = HALF;
            LW:  decoded.size = WORD;
            LBU: begin
                decoded.size        = BYTE;
                decoded.is_unsigned = 1'b1;
            end
            LHU: begin
                decoded.size        = HALF;
                decoded.is_unsigned = 1'b1;
            end
            SB: begin
                decoded.is_store = 1'b1;
                decoded.size     = BYTE;
            end
            SH: begin
                decoded.is_store = 1'b1;
                decoded.size     = HALF;
            end
            SW: begin
                decoded.is_store = 1'b1;
                decoded.size     = WORD;
            end
            // OP_NONE and anything else never reaches the buffer
            default: is_mem = 1'b0;
        endcase

        decoded.dest_tag  = dispatch.dest_tag;
        decoded.imm       = dispatch.imm;
        // tag 0 means the value came with the dispatch
        decoded.rs1_ready = (dispatch.rs1_tag == '0);
        decoded.rs1_tag   = dispatch.rs1_tag;
        decoded.rs1_data  = dispatch.rs1_data;
        decoded.rs2_ready = (dispatch.rs2_tag == '0);
        decoded.rs2_tag   = dispatch.rs2_tag;
        decoded.rs2_data  = dispatch.rs2_data;
    end

    assign decoded_valid = dispatch_valid && is_mem;

endmodule

`default_nettype wire

/* hw/load_store_buffer.sv */
`default_nettype none

module load_store_buffer import lsu_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  lsb_entry_t       decoded,
    input  logic             decoded_valid,
    input  cdb_t             ex_cdb,
    input  cdb_t             load_cdb,
    input  logic             commit_valid,
    input  logic [TAG_W-1:0] commit_tag,
    input  logic             resp_done,
    input  logic [IDX_W-1:0] resp_idx,
    output mem_req_t         mem_req,
    output logic             credit_return
);

    lsb_entry_t             ent [LSB_DEPTH];
    logic [LSB_DEPTH-1:0]   occupied;
    logic [LSB_DEPTH-1:0]   issued;
    logic [LSB_DEPTH-1:0]   committed;
    logic [LSB_DEPTH-1:0]   commit_hit;

    lsb_entry_t             incoming;
    logic [IDX_W-1:0]       alloc_idx;
    logic                   st_found;
    logic [IDX_W-1:0]       st_idx;
    logic                   ld_found;
    logic [IDX_W-1:0]       ld_idx;
    logic [IDX_W-1:0]       sel_idx;
    mem_req_t               issue_req;

    logic [1:0]             free_cnt;
    logic [IDX_W:0]         credit_pend;
    logic [IDX_W:0]         credit_total;

    // returns {ready, data} after looking at both broadcasts
    function automatic logic [XLEN:0] wake(logic rdy, logic [TAG_W-1:0] tag,
                                           logic [XLEN-1:0] data, cdb_t a, cdb_t b);
        if (!rdy && a.valid && a.tag == tag) begin
            return {1'b1, a.data};
        end
        if (!rdy && b.valid && b.tag == tag) begin
            return {1'b1, b.data};
        end
        return {rdy, data};
    endfunction

    // dispatch also catches a broadcast from the same cycle
    always_comb begin
        incoming = decoded;
        {incoming.rs1_ready, incoming.rs1_data} =
            wake(decoded.rs1_ready, decoded.rs1_tag, decoded.rs1_data, ex_cdb, load_cdb);
        {incoming.rs2_ready, incoming.rs2_data} =
            wake(decoded.rs2_ready, decoded.rs2_tag, decoded.rs2_data, ex_cdb, load_cdb);
    end

    always_comb begin
        alloc_idx = '0;
        st_found  = 1'b0;
        st_idx    = '0;
        ld_found  = 1'b0;
        ld_idx    = '0;
        for (int i = LSB_DEPTH - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < LSB_DEPTH; i++) begin
            commit_hit[i] = commit_valid && occupied[i] && ent[i].is_store &&
                            !committed[i] && ent[i].dest_tag == commit_tag;
            if (!st_found && occupied[i] && committed[i] && ent[i].is_store &&
                ent[i].rs1_ready && ent[i].rs2_ready) begin
                st_found = 1'b1;
                st_idx   = IDX_W'(i);
            end
            if (!ld_found && occupied[i] && !issued[i] && !ent[i].is_store &&
                ent[i].rs1_ready) begin
                ld_found = 1'b1;
                ld_idx   = IDX_W'(i);
            end
        end
    end

    // committed stores win over loads
    assign sel_idx = st_found ? st_idx : ld_idx;

    always_comb begin
        issue_req.valid       = st_found || ld_found;
        issue_req.is_store    = ent[sel_idx].is_store;
        issue_req.size        = ent[sel_idx].size;
        issue_req.is_unsigned = ent[sel_idx].is_unsigned;
        issue_req.idx         = sel_idx;
        issue_req.tag         = ent[sel_idx].dest_tag;
        issue_req.addr        = ent[sel_idx].rs1_data +
                                {{(XLEN-IMM_W){ent[sel_idx].imm[IMM_W-1]}}, ent[sel_idx].imm};
        issue_req.wdata       = ent[sel_idx].rs2_data;
    end

    always_ff @(posedge clk) begin
        mem_req <= issue_req;
        if (reset) begin
            mem_req.valid <= 1'b0;
        end
    end

    // entry payload, operands keep snooping while they wait
    always_ff @(posedge clk) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            {ent[i].rs1_ready, ent[i].rs1_data} <=
                wake(ent[i].rs1_ready, ent[i].rs1_tag, ent[i].rs1_data, ex_cdb, load_cdb);
            {ent[i].rs2_ready, ent[i].rs2_data} <=
                wake(ent[i].rs2_ready, ent[i].rs2_tag, ent[i].rs2_data, ex_cdb, load_cdb);
        end
        if (decoded_valid) begin
            ent[alloc_idx] <= incoming;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied  <= '0;
            issued    <= '0;
            committed <= '0;
        end else begin
            committed <= committed | commit_hit;
            if (st_found) begin
                occupied[st_idx] <= 1'b0;
            end else if (ld_found) begin
                issued[ld_idx] <= 1'b1;
            end
            // loads leave once their data is back
            if (resp_done) begin
                occupied[resp_idx] <= 1'b0;
                issued[resp_idx]   <= 1'b0;
            end
            if (decoded_valid) begin
                occupied[alloc_idx]  <= 1'b1;
                issued[alloc_idx]    <= 1'b0;
                committed[alloc_idx] <= 1'b0;
            end
        end
    end

    // up to two frees per cycle, returned one pulse at a time
    assign free_cnt     = {1'b0, st_found} + {1'b0, resp_done};
    assign credit_total = credit_pend + (IDX_W+1)'(free_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_pend   <= '0;
            credit_return <= 1'b0;
        end else if (credit_total != '0) begin
            credit_pend   <= credit_total - 1'b1;
            credit_return <= 1'b1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        decoded_valid |-> !(&occupied))
        else $error("dispatch while every entry is taken");

    a_commit_unique: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> $onehot(commit_hit))
        else $error("commit tag %0d does not name one waiting store", commit_tag);

    a_resp_is_load: assert property (@(posedge clk) disable iff (reset)
        resp_done |-> occupied[resp_idx] && issued[resp_idx] && !ent[resp_idx].is_store)
        else $error("response for entry %0d which holds no issued load", resp_idx);

endmodule

`default_nettype wire

/* hw/lsu_data_mem.sv */
`default_nettype none

module lsu_data_mem import lsu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  mem_req,
    output mem_resp_t mem_resp
);

    logic [XLEN-1:0]      mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0] word;
    logic [XLEN/8-1:0]    be;
    logic [XLEN-1:0]      lane_data;
    mem_resp_t            stage0;
    mem_resp_t            pipe [MEM_LATENCY];

    assign word = mem_req.addr[MEM_IDX_W+1:2];

    // replicate the store data so every lane sees it
    always_comb begin
        case (mem_req.size)
            BYTE: begin
                be        = 4'b0001 << mem_req.addr[1:0];
                lane_data = {4{mem_req.wdata[7:0]}};
            end
            HALF: begin
                be        = 4'b0011 << mem_req.addr[1:0];
                lane_data = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                be        = '1;
                lane_data = mem_req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.is_store) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (be[b]) begin
                    mem[word][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        stage0.valid       = mem_req.valid && !mem_req.is_store;
        stage0.idx         = mem_req.idx;
        stage0.tag         = mem_req.tag;
        stage0.size        = mem_req.size;
        stage0.is_unsigned = mem_req.is_unsigned;
        stage0.raw         = mem[word];
        stage0.lo          = mem_req.addr[1:0];
    end

    // read at the request edge, then delay to the fixed latency
    always_ff @(posedge clk) begin
        pipe[0] <= stage0;
        for (int k = 1; k < MEM_LATENCY; k++) begin
            pipe[k] <= pipe[k-1];
        end
        if (reset) begin
            for (int k = 0; k < MEM_LATENCY; k++) begin
                pipe[k].valid <= 1'b0;
            end
        end
    end

    assign mem_resp = pipe[MEM_LATENCY-1];

    a_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid |->
            (mem_req.size != HALF || !mem_req.addr[0]) &&
            (mem_req.size != WORD || mem_req.addr[1:0] == 2'b00))
        else $error("misaligned access at %h", mem_req.addr);

endmodule

`default_nettype wire

/* hw/load_result_align.sv */
`default_nettype none

module load_result_align import lsu_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  mem_resp_t        mem_resp,
    output cdb_t             load_cdb,
    output logic             resp_done,
    output logic [IDX_W-1:0] resp_idx
);

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] ext_data;

    // bring the addressed lane down to bit 0
    assign shifted = mem_resp.raw >> {mem_resp.lo, 3'b000};

    always_comb begin
        case (mem_resp.size)
            BYTE: begin
                if (mem_resp.is_unsigned) begin
                    ext_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
                end else begin
                    ext_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
                end
            end
            HALF: begin
                if (mem_resp.is_unsigned) begin
                    ext_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
                end else begin
                    ext_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
                end
            end
            default: ext_data = mem_resp.raw;
        endcase
    end

    always_ff @(posedge clk) begin
        load_cdb.valid <= mem_resp.valid;
        load_cdb.tag   <= mem_resp.tag;
        load_cdb.data  <= ext_data;
        if (reset) begin
            load_cdb.valid <= 1'b0;
        end
    end

    // entry can be freed as soon as its data is captured
    assign resp_done = mem_resp.valid;
    assign resp_idx  = mem_resp.idx;

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  dispatch_t        dispatch,
    input  logic             dispatch_valid,
    input  cdb_t             ex_cdb,
    input  logic             commit_valid,
    input  logic [TAG_W-1:0] commit_tag,
    output logic             credit_return,
    output cdb_t             load_cdb
);

    lsb_entry_t       decoded;
    logic             decoded_valid;
    mem_req_t         mem_req;
    mem_resp_t        mem_resp;
    logic             resp_done;
    logic [IDX_W-1:0] resp_idx;

    lsu_dispatch_decode u_decode (
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .decoded        (decoded),
        .decoded_valid  (decoded_valid)
    );

    // load results come back in as a second wakeup source
    load_store_buffer u_lsb (
        .clk           (clk),
        .reset         (reset),
        .decoded       (decoded),
        .decoded_valid (decoded_valid),
        .ex_cdb        (ex_cdb),
        .load_cdb      (load_cdb),
        .commit_valid  (commit_valid),
        .commit_tag    (commit_tag),
        .resp_done     (resp_done),
        .resp_idx      (resp_idx),
        .mem_req       (mem_req),
        .credit_return (credit_return)
    );

    lsu_data_mem u_mem (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    load_result_align u_align (
        .clk       (clk),
        .reset     (reset),
        .mem_resp  (mem_resp),
        .load_cdb  (load_cdb),
        .resp_done (resp_done),
        .resp_idx  (resp_idx)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WAIT_LIMIT      = 100;

    logic             clk;
    logic             reset;
    dispatch_t        dispatch;
    logic             dispatch_valid;
    cdb_t             ex_cdb;
    logic             commit_valid;
    logic [TAG_W-1:0] commit_tag;
    logic             credit_return;
    cdb_t             load_cdb;

    // byte view of the data memory, little endian
    logic [7:0]       model_mem [MEM_WORDS*4];
    int               credits;
    int               credit_pulses;
    int               cdb_total;
    int               seen_count [2**TAG_W];
    logic [XLEN-1:0]  seen_data [2**TAG_W];
    int               errors;
    int               failed_tests;
    int               test_start_errors;
    integer           seed;

    tb_clock u_clock (
        .clk (clk)
    );

    lsu_top UUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .ex_cdb         (ex_cdb),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .credit_return  (credit_return),
        .load_cdb       (load_cdb)
    );

    function automatic logic is_mem_op(lsu_op_e op);
        case (op)
            LB, LH, LW, LBU, LHU, SB, SH, SW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_load(lsu_op_e op, logic [XLEN-1:0] addr);
        logic [MEM_IDX_W+1:0] a;
        logic [7:0]           b0;
        logic [7:0]           b1;
        logic [7:0]           b2;
        logic [7:0]           b3;
        a  = addr[MEM_IDX_W+1:0];
        b0 = model_mem[a];
        b1 = model_mem[a + 1];
        b2 = model_mem[a + 2];
        b3 = model_mem[a + 3];
        case (op)
            LW:      return {b3, b2, b1, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'h0000, b1, b0};
            LB:      return {{24{b0[7]}}, b0};
            default: return {24'h000000, b0};
        endcase
    endfunction

    function automatic void model_store(lsu_op_e op, logic [XLEN-1:0] addr,
                                        logic [XLEN-1:0] data);
        logic [MEM_IDX_W+1:0] a;
        a = addr[MEM_IDX_W+1:0];
        model_mem[a] = data[7:0];
        if (op != SB) begin
            model_mem[a + 1] = data[15:8];
        end
        if (op == SW) begin
            model_mem[a + 2] = data[23:16];
            model_mem[a + 3] = data[31:24];
        end
    endfunction

    // mix of load widths for the batch tests, lane offset inside the word
    function automatic lsu_op_e mixed_op(int i);
        case (i % 5)
            0: return LW;
            1: return LH;
            2: return LHU;
            3: return LB;
            default: return LBU;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] lane_of(lsu_op_e op);
        case (op)
            LH, LHU: return 32'd2;
            LB:      return 32'd3;
            LBU:     return 32'd1;
            default: return 32'd0;
        endcase
    endfunction

    // credits, credit pulses and load results, all seen at the clock edge
    always @(posedge clk) begin
        if (reset) begin
            credits = LSB_DEPTH;
        end else begin
            if (credit_return) begin
                credits++;
                credit_pulses++;
            end
            if (dispatch_valid && is_mem_op(dispatch.op)) begin
                credits--;
            end
            if (load_cdb.valid) begin
                seen_count[load_cdb.tag]++;
                seen_data[load_cdb.tag] = load_cdb.data;
                cdb_total++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        errors++;
        $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
    endtask

    task automatic report_failure(string name, string what);
        errors++;
        $display("[ERROR] %s: %s", name, what);
    endtask

    task automatic clear_results();
        for (int t = 0; t < 2**TAG_W; t++) begin
            seen_count[t] = 0;
            seen_data[t]  = '0;
        end
        cdb_total = 0;
    endtask

    task automatic begin_test();
        clear_results();
        test_start_errors = errors;
    endtask

    task automatic end_test(string name);
        if (errors == test_start_errors) begin
            $display("test %s passed", name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic dispatch_op(lsu_op_e op, logic [TAG_W-1:0] dest, logic [XLEN-1:0] base,
                               logic [TAG_W-1:0] base_tag, logic [XLEN-1:0] data,
                               logic [TAG_W-1:0] data_tag, logic [IMM_W-1:0] imm);
        // memory ops need a credit, others go straight through
        while (is_mem_op(op) && credits == 0) begin
            next_cycle();
        end
        dispatch.op       = op;
        dispatch.dest_tag = dest;
        dispatch.imm      = imm;
        dispatch.rs1_tag  = base_tag;
        dispatch.rs1_data = base;
        dispatch.rs2_tag  = data_tag;
        dispatch.rs2_data = data;
        dispatch_valid    = 1'b1;
        next_cycle();
        dispatch_valid    = 1'b0;
    endtask

    task automatic broadcast(logic [TAG_W-1:0] tag, logic [XLEN-1:0] data);
        ex_cdb.valid = 1'b1;
        ex_cdb.tag   = tag;
        ex_cdb.data  = data;
        next_cycle();
        ex_cdb.valid = 1'b0;
    endtask

    task automatic commit_store(logic [TAG_W-1:0] tag);
        commit_valid = 1'b1;
        commit_tag   = tag;
        next_cycle();
        commit_valid = 1'b0;
    endtask

    task automatic wait_credits_full(string name);
        int n;
        n = 0;
        while (credits != LSB_DEPTH && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (credits != LSB_DEPTH) begin
            report_failure(name, "buffer entries were not freed in time");
        end
    endtask

    // store with ready operands, committed right away
    task automatic store_op(string name, lsu_op_e op, logic [XLEN-1:0] addr,
                            logic [XLEN-1:0] data);
        dispatch_op(op, 4'd1, addr - 32'd16, 4'd0, data, 4'd0, 12'd16);
        commit_store(4'd1);
        wait_credits_full(name);
        model_store(op, addr, data);
    endtask

    task automatic load_op(lsu_op_e op, logic [TAG_W-1:0] tag, logic [XLEN-1:0] addr);
        dispatch_op(op, tag, addr, 4'd0, '0, 4'd0, 12'd0);
    endtask

    task automatic check_load(string name, logic [TAG_W-1:0] tag, lsu_op_e op,
                              logic [XLEN-1:0] addr);
        int              n;
        logic [XLEN-1:0] exp;
        exp = expected_load(op, addr);
        n   = 0;
        while (seen_count[tag] == 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (seen_count[tag] == 0) begin
            report_failure(name, $sformatf("no load result for tag %0d", tag));
        end else if (seen_data[tag] !== exp) begin
            report_mismatch(name, exp, seen_data[tag]);
        end
    endtask

    task automatic check_load_set(string name, logic [XLEN-1:0] a);
        clear_results();
        load_op(LW, 4'd2, a);
        load_op(LH, 4'd3, a + 2);
        load_op(LHU, 4'd4, a);
        load_op(LB, 4'd5, a + 3);
        load_op(LBU, 4'd6, a + 1);
        check_load(name, 4'd2, LW, a);
        check_load(name, 4'd3, LH, a + 2);
        check_load(name, 4'd4, LHU, a);
        check_load(name, 4'd5, LB, a + 3);
        check_load(name, 4'd6, LBU, a + 1);
    endtask

    task automatic run_ready_loads(string name, logic [XLEN-1:0] region);
        for (int i = 0; i < LSB_DEPTH; i++) begin
            store_op(name, SW, region + 4 * i, $random(seed));
        end
        clear_results();
        for (int i = 0; i < LSB_DEPTH; i++) begin
            load_op(mixed_op(i), TAG_W'(i + 1), region + 4 * i + lane_of(mixed_op(i)));
        end
        for (int i = 0; i < LSB_DEPTH; i++) begin
            check_load(name, TAG_W'(i + 1), mixed_op(i),
                       region + 4 * i + lane_of(mixed_op(i)));
        end
        wait_credits_full(name);
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (seen_count[i + 1] != 1) begin
                report_mismatch(name, 1, seen_count[i + 1]);
            end
        end
        if (cdb_total != LSB_DEPTH) begin
            report_mismatch(name, LSB_DEPTH, cdb_total);
        end
    endtask

    task automatic test_round_trip();
        begin_test();
        store_op("round_trip", SW, 32'h080, $random(seed));
        check_load_set("round_trip", 32'h080);
        store_op("round_trip", SH, 32'h082, $random(seed));
        check_load_set("round_trip", 32'h080);
        store_op("round_trip", SB, 32'h081, $random(seed));
        check_load_set("round_trip", 32'h080);
        end_test("round_trip");
    endtask

    task automatic test_operand_wakeup();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] ptr;
        base = 32'h200;
        val  = $random(seed);
        begin_test();
        // store waits on tags 5 and 6 even though it is committed
        dispatch_op(SW, 4'd1, '0, 4'd5, '0, 4'd6, 12'd8);
        commit_store(4'd1);
        repeat (10) next_cycle();
        if (credits != LSB_DEPTH - 1) begin
            report_failure("operand_wakeup", "store left the buffer before its operands");
        end
        broadcast(4'd5, base);
        broadcast(4'd6, val);
        wait_credits_full("operand_wakeup");
        model_store(SW, base + 8, val);
        dispatch_op(LW, 4'd2, '0, 4'd7, '0, 4'd0, 12'd8);
        repeat (10) next_cycle();
        if (cdb_total != 0) begin
            report_failure("operand_wakeup", "load result appeared before its base");
        end
        broadcast(4'd7, base);
        check_load("operand_wakeup", 4'd2, LW, base + 8);
        // pointer chase, second load takes its base from the load CDB
        ptr = 32'h300 | ($random(seed) & 32'h0fc);
        store_op("operand_wakeup", SW, 32'h240, ptr);
        store_op("operand_wakeup", SW, ptr, $random(seed));
        dispatch_op(LW, 4'd4, '0, 4'd3, '0, 4'd0, 12'd0);
        load_op(LW, 4'd3, 32'h240);
        check_load("operand_wakeup", 4'd3, LW, 32'h240);
        check_load("operand_wakeup", 4'd4, LW, ptr);
        wait_credits_full("operand_wakeup");
        end_test("operand_wakeup");
    endtask

    task automatic test_commit_gating();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] new_val;
        a       = 32'h1c0;
        new_val = $random(seed);
        begin_test();
        store_op("commit_gating", SW, a, $random(seed));
        dispatch_op(SW, 4'd1, a, 4'd0, new_val, 4'd0, 12'd0);
        // memory still holds the old word
        load_op(LW, 4'd2, a);
        check_load("commit_gating", 4'd2, LW, a);
        commit_store(4'd1);
        wait_credits_full("commit_gating");
        model_store(SW, a, new_val);
        load_op(LW, 4'd3, a);
        check_load("commit_gating", 4'd3, LW, a);
        wait_credits_full("commit_gating");
        end_test("commit_gating");
    endtask

    task automatic test_credit_flow();
        int pulses;
        begin_test();
        for (int i = 0; i < LSB_DEPTH; i++) begin
            store_op("credit_flow", SW, 32'h100 + 4 * i, $random(seed));
        end
        for (int i = 0; i < LSB_DEPTH; i++) begin
            dispatch_op(LW, TAG_W'(i + 1), '0, 4'd9, '0, 4'd0, IMM_W'(4 * i));
        end
        if (credits != 0) begin
            report_mismatch("credit_flow", 0, credits);
        end
        pulses = credit_pulses;
        repeat (10) next_cycle();
        if (credit_pulses != pulses) begin
            report_failure("credit_flow", "credit returned while every base was pending");
        end
        broadcast(4'd9, 32'h100);
        for (int i = 0; i < LSB_DEPTH; i++) begin
            check_load("credit_flow", TAG_W'(i + 1), LW, 32'h100 + 4 * i);
        end
        wait_credits_full("credit_flow");
        repeat (5) next_cycle();
        if (credit_pulses - pulses != LSB_DEPTH) begin
            report_mismatch("credit_flow", LSB_DEPTH, credit_pulses - pulses);
        end
        if (credits != LSB_DEPTH) begin
            report_mismatch("credit_flow", LSB_DEPTH, credits);
        end
        end_test("credit_flow");
    endtask

    task automatic test_loads_in_flight();
        begin_test();
        run_ready_loads("loads_in_flight", 32'h140);
        end_test("loads_in_flight");
    endtask

    task automatic test_non_memory_ops();
        int pulses;
        begin_test();
        pulses = credit_pulses;
        dispatch_op(OP_NONE, 4'd1, $random(seed), 4'd0, $random(seed), 4'd0, 12'd0);
        dispatch_op(OP_NONE, 4'd2, $random(seed), 4'd0, $random(seed), 4'd0, 12'd4);
        dispatch_op(lsu_op_e'(4'd15), 4'd3, '0, 4'd0, '0, 4'd0, 12'd0);
        repeat (10) next_cycle();
        if (cdb_total != 0) begin
            report_failure("non_memory_ops", "non-memory op produced a load result");
        end
        if (credit_pulses != pulses) begin
            report_failure("non_memory_ops", "non-memory op returned a credit");
        end
        // all eight entries must still be free
        run_ready_loads("non_memory_ops", 32'h380);
        end_test("non_memory_ops");
    endtask

    initial begin
        seed              = 32'h8fddd7bf;
        errors            = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        credits           = LSB_DEPTH;
        credit_pulses     = 0;
        cdb_total         = 0;
        reset             = 1'b1;
        dispatch          = '0;
        dispatch_valid    = 1'b0;
        ex_cdb            = '0;
        commit_valid      = 1'b0;
        commit_tag        = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_round_trip();
        test_operand_wakeup();
        test_commit_gating();
        test_credit_flow();
        test_loads_in_flight();
        test_non_memory_ops();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test is stuck",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hw/lsu_pkg.sv
hw/lsu_dispatch_decode.sv
hw/load_store_buffer.sv
hw/lsu_data_mem.sv
hw/load_result_align.sv
hw/lsu_top.sv
verification/tb_clock.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the lsu testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
